//--- Makefile
VERILATOR ?= verilator
TOP       := tb_aes_mix_columns
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- design/aes_mix_columns_exec.sv
// Second pipeline stage: mixes all four columns of the decoded state in
// one cycle and registers the result. Beats flagged with err keep their
// input state; valid, op and err ride along unchanged.

`default_nettype none

module aes_mix_columns_exec (
  input  logic         clk_i,
  input  logic         rst_n_i,
  aes_mix_stage_if.dst dec_i,
  aes_mix_stage_if.src exe_o
);

  aes_pkg::aes_state_t mixed;
  aes_pkg::aes_state_t next_state;

  // One mixer per column
  for (genvar c = 0; c < 4; c++) begin : gen_col
    aes_mix_single_column aes_mix_single_column_i (
      .op_i   (dec_i.op),
      .data_i (dec_i.state[32*c +: 32]),
      .data_o (mixed[32*c +: 32])
    );
  end

  // Bypass for illegal direction codes
  assign next_state = dec_i.err ? dec_i.state : mixed;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exe_o.valid <= 1'b0;
    end else begin
      exe_o.valid <= dec_i.valid;
    end
  end

  // Payload moves only with a beat
  always_ff @(posedge clk_i) begin
    if (dec_i.valid) begin
      exe_o.op    <= dec_i.op;
      exe_o.err   <= dec_i.err;
      exe_o.state <= next_state;
    end
  end

  // Erroneous beat leaves the stage with its state untouched
  err_bypass_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (dec_i.valid && dec_i.err) |=>
      (exe_o.valid && exe_o.err && exe_o.state == $past(dec_i.state))
  ) else $error("erroneous beat modified by execute stage");

endmodule

`default_nettype wire

//--- design/aes_mix_columns_top.sv
// MixColumns unit top level: decode, execute and result stages in a row.
// Sender side uses credits (RESULT_DEPTH after reset, one back per
// in_credit_o pulse); consumer side is plain valid/ready.
// Latency from an accepted beat to out_valid_o is three cycles when empty.

`default_nettype none

module aes_mix_columns_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                in_valid_i,
  input  aes_pkg::ciph_op_e   in_op_i,
  input  aes_pkg::aes_state_t in_state_i,
  output logic                in_credit_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output aes_pkg::aes_state_t out_state_o,
  output logic                out_err_o
);

  // Stage links
  aes_mix_stage_if dec_to_exe ();
  aes_mix_stage_if exe_to_res ();

  // Register beat, flag illegal direction
  aes_mix_decode aes_mix_decode_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .in_op_i    (in_op_i),
    .in_state_i (in_state_i),
    .dec_o      (dec_to_exe.src)
  );

  // Mix four columns
  aes_mix_columns_exec aes_mix_columns_exec_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dec_i   (dec_to_exe.dst),
    .exe_o   (exe_to_res.src)
  );

  // Queue results, return credits
  aes_mix_result_buf aes_mix_result_buf_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .res_i       (exe_to_res.dst),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .out_state_o (out_state_o),
    .out_err_o   (out_err_o),
    .in_credit_o (in_credit_o)
  );

endmodule

`default_nettype wire

//--- design/aes_mix_decode.sv
// First pipeline stage: registers each sender beat and classifies its
// direction code. Codes other than forward or inverse set err, and the
// later stages then pass the state through untouched.

`default_nettype none

module aes_mix_decode (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                in_valid_i,
  input  aes_pkg::ciph_op_e   in_op_i,
  input  aes_pkg::aes_state_t in_state_i,
  aes_mix_stage_if.src        dec_o
);

  logic op_illegal;

  // Anything but the two legal codes
  assign op_illegal = !(in_op_i inside {aes_pkg::CIPH_FWD, aes_pkg::CIPH_INV});

  // Valid flag, cleared on reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= in_valid_i;
    end
  end

  // Payload, loaded only on an accepted beat
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      dec_o.op    <= in_op_i;
      dec_o.err   <= op_illegal;
      dec_o.state <= in_state_i;
    end
  end

  // Sender must drive a known direction with every beat
  op_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i |-> !$isunknown(in_op_i)
  ) else $error("in_op_i unknown while in_valid_i is high");

endmodule

`default_nettype wire

//--- design/aes_mix_result_buf.sv
// Last stage: a small FIFO that holds mixed states for the consumer.
// Results leave on a valid/ready handshake, in arrival order. Each pop
// returns one input credit to the sender on the following cycle.
// The FIFO never needs to refuse a push as long as the sender keeps to
// its credit count, so there is no full back-pressure toward execute.

`default_nettype none

module aes_mix_result_buf (
  input  logic                clk_i,
  input  logic                rst_n_i,
  aes_mix_stage_if.dst        res_i,
  input  logic                out_ready_i,
  output logic                out_valid_o,
  output aes_pkg::aes_state_t out_state_o,
  output logic                out_err_o,
  output logic                in_credit_o
);

  localparam int unsigned PtrW = aes_pkg::RESULT_PTR_W;
  localparam int unsigned CntW = aes_pkg::RESULT_CNT_W;
  localparam int unsigned Last = aes_pkg::RESULT_DEPTH - 1;

  // Storage, no reset
  aes_pkg::aes_state_t mem_state [aes_pkg::RESULT_DEPTH];
  logic                mem_err   [aes_pkg::RESULT_DEPTH];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;
  logic            credit_q;

  assign push = res_i.valid;
  assign pop  = out_valid_o && out_ready_i;

  // Head of queue straight to the consumer
  assign out_valid_o = (cnt_q != '0);
  assign out_state_o = mem_state[rd_ptr_q];
  assign out_err_o   = mem_err[rd_ptr_q];
  assign in_credit_o = credit_q;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_state[wr_ptr_q] <= res_i.state;
      mem_err[wr_ptr_q]   <= res_i.err;
    end
  end

  // Pointers wrap at the last entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Last)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Last)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Occupancy, unchanged on simultaneous push and pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Credit goes back the cycle after the pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop;
    end
  end

  // A push into a full FIFO means the sender overran its credits
  no_overflow_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push |-> (cnt_q < CntW'(aes_pkg::RESULT_DEPTH))
  ) else $error("result FIFO push while full, credit rule broken");

  // Head entry holds still while the consumer stalls
  stall_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_state_o) && $stable(out_err_o))
  ) else $error("result output changed under stall");

endmodule

`default_nettype wire

//--- design/aes_mix_single_column.sv
// Forward or inverse MixColumns of one 32-bit column, purely combinational.
// Forward mix is built from pairwise XORs and their doubles; the inverse
// adds a 4x/8x correction term on top, so no second matrix is needed.

`default_nettype none

module aes_mix_single_column (
  input  aes_pkg::ciph_op_e op_i,
  input  aes_pkg::aes_word_t data_i,
  output aes_pkg::aes_word_t data_o
);

  aes_pkg::aes_byte_t a      [4];
  aes_pkg::aes_byte_t x      [4];
  aes_pkg::aes_byte_t x_mul2 [4];
  aes_pkg::aes_byte_t y      [2];
  aes_pkg::aes_byte_t y2;
  aes_pkg::aes_byte_t z      [2];
  aes_pkg::aes_byte_t z_sel  [2];
  logic               inv;

  always_comb begin
    // Split into rows, row 0 lowest
    for (int r = 0; r < 4; r++) begin
      a[r] = data_i[8*r +: 8];
    end

    // Neighbouring row sums
    x[0] = a[0] ^ a[3];
    x[1] = a[3] ^ a[2];
    x[2] = a[2] ^ a[1];
    x[3] = a[1] ^ a[0];
    for (int i = 0; i < 4; i++) begin
      x_mul2[i] = aes_pkg::aes_mul2(x[i]);
    end

    // Opposite row sums times 4
    y[0] = aes_pkg::aes_mul4(a[3] ^ a[1]);
    y[1] = aes_pkg::aes_mul4(a[2] ^ a[0]);

    // Sum of all rows times 8
    y2 = aes_pkg::aes_mul2(y[0] ^ y[1]);

    // Inverse correction, z[1] for even rows and z[0] for odd rows
    z[0] = y2 ^ y[0];
    z[1] = y2 ^ y[1];

    // Only the inverse direction adds the correction
    inv      = (op_i == aes_pkg::CIPH_INV);
    z_sel[0] = inv ? z[0] : 8'h00;
    z_sel[1] = inv ? z[1] : 8'h00;

    // 02 03 01 01 per row, plus correction
    data_o[7:0]   = a[1] ^ x_mul2[3] ^ x[1] ^ z_sel[1];
    data_o[15:8]  = a[0] ^ x_mul2[2] ^ x[1] ^ z_sel[0];
    data_o[23:16] = a[3] ^ x_mul2[1] ^ x[3] ^ z_sel[1];
    data_o[31:24] = a[2] ^ x_mul2[0] ^ x[3] ^ z_sel[0];
  end

endmodule

`default_nettype wire

//--- design/aes_mix_stage_if.sv
// Carries one state beat between two pipeline stages of the MixColumns unit.
// The producing stage takes src, the consuming stage takes dst.
// There is no ready signal; overflow is ruled out by input credits.

`default_nettype none

interface aes_mix_stage_if;

  // Beat present this cycle
  logic valid;
  // Direction code as received
  aes_pkg::ciph_op_e op;
  // Illegal direction, state passes unchanged
  logic err;
  // Payload
  aes_pkg::aes_state_t state;

  modport src (
    output valid,
    output op,
    output err,
    output state
  );

  modport dst (
    input valid,
    input op,
    input err,
    input state
  );

endinterface

`default_nettype wire

//--- design/aes_pkg.sv
// Shared types, constants and GF(2^8) helpers for the MixColumns unit.
// Every design file refers to these through scoped names, the testbench
// too (it reads RESULT_DEPTH for its initial credit count).

`default_nettype none

package aes_pkg;

  // One state byte
  typedef logic [7:0] aes_byte_t;

  // One column of four bytes, row 0 in the low byte
  typedef logic [31:0] aes_word_t;

  // Full state, column c at bits 32c..32c+31
  typedef logic [127:0] aes_state_t;

  // Cipher direction, one-hot style codes
  // 2'b00 and 2'b11 are illegal and flagged by decode
  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  // Result FIFO depth, also the sender's credit count after reset
  localparam int unsigned RESULT_DEPTH = 4;

  // Occupancy counter must hold 0..RESULT_DEPTH
  localparam int unsigned RESULT_CNT_W = $clog2(RESULT_DEPTH + 1);

  // Read/write pointer width
  localparam int unsigned RESULT_PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;

  // Field polynomial x^8 + x^4 + x^3 + x + 1, low byte only
  localparam aes_byte_t AES_POLY_LOW = 8'h1b;

  // Multiply by x in GF(2^8)
  function automatic aes_byte_t aes_mul2(input aes_byte_t b);
    aes_byte_t shifted;
    shifted = {b[6:0], 1'b0};
    // Reduce when the top bit falls out
    if (b[7]) begin
      shifted = shifted ^ AES_POLY_LOW;
    end
    return shifted;
  endfunction

  // Multiply by x^2, two chained doublings
  function automatic aes_byte_t aes_mul4(input aes_byte_t b);
    aes_byte_t twice;
    twice = aes_mul2(b);
    return aes_mul2(twice);
  endfunction

endpackage

`default_nettype wire

//--- src.f
design/aes_pkg.sv
design/aes_mix_stage_if.sv
design/aes_mix_single_column.sv
design/aes_mix_decode.sv
design/aes_mix_columns_exec.sv
design/aes_mix_result_buf.sv
design/aes_mix_columns_top.sv
tests/tb_aes_mix_columns.sv

//--- tests/tb_aes_mix_columns.sv
// Self-checking random testbench for the MixColumns unit.
// Sends random states under the input credit rule and stalls the consumer
// at random. Every result is compared with a textbook MixColumns model.
// Also covers FIPS-197 vectors, the inverse round trip, latency and credits.

`default_nettype none

module tb_aes_mix_columns;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_RESULTS = 2000;
  localparam int STEP_LIMIT  = 200000;
  localparam int WAIT_LIMIT  = 50;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  aes_pkg::ciph_op_e   in_op;
  aes_pkg::aes_state_t in_state;
  logic                in_credit;
  logic                out_valid;
  logic                out_ready;
  aes_pkg::aes_state_t out_state;
  logic                out_err;

  // Expected results in send order
  aes_pkg::aes_state_t exp_state_q [$];
  logic                exp_err_q   [$];
  logic [31:0]         lcg_q;
  int                  credits;
  int                  results_seen;
  // Handshake seen before the coming edge
  logic                pop_next;
  logic                stall_prev;
  aes_pkg::aes_state_t held_state;
  logic                held_err;
  aes_pkg::aes_state_t last_state;

  aes_mix_columns_top aes_mix_columns_top_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .in_op_i     (in_op),
    .in_state_i  (in_state),
    .in_credit_o (in_credit),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_state_o (out_state),
    .out_err_o   (out_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] rand_next();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  // Doubling in GF(2^8) with polynomial 0x11b
  function automatic aes_pkg::aes_byte_t xtime(input aes_pkg::aes_byte_t b);
    aes_pkg::aes_byte_t s;
    s = {b[6:0], 1'b0};
    if (b[7]) begin
      s = s ^ 8'h1b;
    end
    return s;
  endfunction

  // Shift-and-add product
  function automatic aes_pkg::aes_byte_t gf_mul(input aes_pkg::aes_byte_t b,
                                                input aes_pkg::aes_byte_t k);
    aes_pkg::aes_byte_t acc;
    aes_pkg::aes_byte_t p;
    acc = 8'h00;
    p   = b;
    for (int i = 0; i < 8; i++) begin
      if (k[i]) begin
        acc = acc ^ p;
      end
      p = xtime(p);
    end
    return acc;
  endfunction

  function automatic aes_pkg::aes_state_t model_mix(input aes_pkg::aes_state_t st,
                                                    input logic inverse);
    aes_pkg::aes_word_t  coef;
    aes_pkg::aes_byte_t  acc;
    aes_pkg::aes_state_t res;
    // First matrix row with coefficient j in byte j
    coef = inverse ? 32'h090d0b0e : 32'h01010302;
    res  = '0;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        acc = 8'h00;
        // Row r is row 0 rotated right by r
        for (int j = 0; j < 4; j++) begin
          acc = acc ^ gf_mul(st[32*c + 8*j +: 8], coef[8*((j + 4 - r) % 4) +: 8]);
        end
        res[32*c + 8*r +: 8] = acc;
      end
    end
    return res;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_state(input aes_pkg::aes_state_t exp_v,
                             input aes_pkg::aes_state_t got, input string what);
    if (got !== exp_v) begin
      abort_run($sformatf("error at %0t: %s is %032h, expected %032h",
                          $realtime, what, got, exp_v));
    end
  endtask

  task automatic check_err(input logic exp_v, input logic got, input string what);
    if (got !== exp_v) begin
      abort_run($sformatf("error at %0t: %s is %b, expected %b",
                          $realtime, what, got, exp_v));
    end
  endtask

  // Sampled 1 ns after the edge once inputs for the next edge are set
  task automatic monitor_outputs();
    if ($isunknown(out_valid) || $isunknown(in_credit)) begin
      abort_run("out_valid_o or in_credit_o went unknown");
    end
    // Credit exactly one cycle after each pop
    if (in_credit !== pop_next) begin
      abort_run($sformatf("error at %0t: in_credit_o is %b, expected %b",
                          $realtime, in_credit, pop_next));
    end
    if (in_credit) begin
      credits++;
    end
    // Head frozen while consumer stalls
    if (stall_prev) begin
      if (!out_valid) begin
        abort_run("out_valid_o dropped while the consumer stalled");
      end
      check_state(held_state, out_state, "stalled out_state_o");
      check_err(held_err, out_err, "stalled out_err_o");
    end
    if (out_valid && exp_state_q.size() == 0) begin
      abort_run("out_valid_o high with no beat outstanding");
    end
    pop_next   = out_valid && out_ready;
    stall_prev = out_valid && !out_ready;
    held_state = out_state;
    held_err   = out_err;
    if (pop_next) begin
      check_state(exp_state_q.pop_front(), out_state, "out_state_o");
      check_err(exp_err_q.pop_front(), out_err, "out_err_o");
      last_state = out_state;
      results_seen++;
    end
  endtask

  task automatic run_cycle(input logic send, input logic [1:0] code,
                           input aes_pkg::aes_state_t st, input logic ready);
    @(posedge clk);
    #1;
    if (send && credits <= 0) begin
      abort_run("sender would go below zero credits");
    end
    in_valid  = send;
    in_op     = aes_pkg::ciph_op_e'(code);
    in_state  = st;
    out_ready = ready;
    if (send) begin
      credits--;
      case (code)
        2'b01:   exp_state_q.push_back(model_mix(st, 1'b0));
        2'b10:   exp_state_q.push_back(model_mix(st, 1'b1));
        default: exp_state_q.push_back(st);
      endcase
      exp_err_q.push_back(!(code == 2'b01 || code == 2'b10));
    end
    monitor_outputs();
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    while (!(credits == int'(aes_pkg::RESULT_DEPTH) && exp_state_q.size() == 0)) begin
      if (n >= WAIT_LIMIT) begin
        abort_run("timeout: results or credits did not come back while draining");
      end
      run_cycle(1'b0, 2'b01, '0, 1'b1);
      n++;
    end
  endtask

  // One beat into an empty unit with the consumer always ready
  task automatic run_directed(input logic [1:0] code, input aes_pkg::aes_state_t st,
                              output aes_pkg::aes_state_t got);
    int n;
    drain_all();
    run_cycle(1'b1, code, st, 1'b1);
    n = 0;
    while (!pop_next) begin
      if (n >= WAIT_LIMIT) begin
        abort_run("timeout: no result for a directed beat");
      end
      run_cycle(1'b0, 2'b01, '0, 1'b1);
      n++;
    end
    if (n != 3) begin
      abort_run($sformatf("error at %0t: out_valid_o rose %0d cycles after the beat, expected 3",
                          $realtime, n));
    end
    got = last_state;
  endtask

  initial begin
    aes_pkg::aes_state_t fips_in;
    aes_pkg::aes_state_t fips_out;
    aes_pkg::aes_state_t got;
    aes_pkg::aes_state_t back;
    aes_pkg::aes_state_t st;
    logic [31:0]         r;
    logic [1:0]          code;
    int                  guard;

    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_op        = aes_pkg::CIPH_FWD;
    in_state     = '0;
    out_ready    = 1'b0;
    lcg_q        = 32'hd147_3e36;
    credits      = int'(aes_pkg::RESULT_DEPTH);
    results_seen = 0;
    pop_next     = 1'b0;
    stall_prev   = 1'b0;
    held_state   = '0;
    held_err     = 1'b0;
    last_state   = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Nothing may come out while idle after reset
    for (int i = 0; i < 8; i++) begin
      r = rand_next();
      run_cycle(1'b0, 2'b01, '0, r[31]);
    end

    // FIPS-197 columns with row 0 in the low byte
    fips_in  = {32'hc6c6c6c6, 32'h01010101, 32'h5c220af2, 32'h455313db};
    fips_out = {32'hc6c6c6c6, 32'h01010101, 32'h9d58dc9f, 32'hbca14d8e};
    run_directed(2'b01, fips_in, got);
    check_state(fips_out, got, "FIPS-197 forward vector");
    run_directed(2'b10, got, back);
    check_state(fips_in, back, "inverse of forward result");
    run_directed(2'b11, fips_in, got);
    check_state(fips_in, got, "illegal code pass-through");

    // Random traffic with consumer stalls
    guard = 0;
    while (results_seen < NUM_RESULTS) begin
      if (guard >= STEP_LIMIT) begin
        abort_run("timeout: random phase did not collect enough results");
      end
      r = rand_next();
      // One in eight codes illegal
      if (r[31:29] == 3'b000) begin
        code = r[28] ? 2'b11 : 2'b00;
      end else begin
        code = r[28] ? 2'b10 : 2'b01;
      end
      for (int w = 0; w < 4; w++) begin
        st[32*w +: 32] = rand_next();
      end
      run_cycle(credits > 0 && r[27:26] != 2'b00, code, st, r[25:24] != 2'b00);
      guard++;
    end

    // Every credit back and nothing left in flight
    drain_all();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire
